//--- src/sifhPkg.sv
`default_nettype none

package sifhPkg;

    // bin index width, 6 gives 64 bins
    localparam int binWDef = 6;

    // width of one bin count
    localparam int countWDef = 16;

    // samples per acquisition
    localparam int acqLenDef = 1024;

    // accumulator control
    typedef enum logic [1:0] {
        accIdle  = 2'd0, // waiting for start
        accRun   = 2'd1, // taking samples
        accDrain = 2'd2  // last write in flight
    } accState_t;

    // readout control
    typedef enum logic [1:0] {
        rdIdle = 2'd0, // waiting for rdStart
        rdRun  = 2'd1, // walking read addresses
        rdLast = 2'd2  // final bin streamed and cleared
    } rdState_t;

endpackage

`default_nettype wire

//--- src/histBank.sv
`default_nettype none

module histBank #(
    parameter int binW   = sifhPkg::binWDef,
    parameter int countW = sifhPkg::countWDef
) (
    input  logic              clk,
    input  logic              res,
    input  logic              roBusy,
    input  logic [binW-1:0]   accRdAddr,
    input  logic              accWrEn,
    input  logic [binW-1:0]   accWrAddr,
    input  logic [countW-1:0] accWrData,
    input  logic [binW-1:0]   roRdAddr,
    input  logic              roWrEn,
    input  logic [binW-1:0]   roWrAddr,
    output logic [countW-1:0] bankRdData
);

    localparam int depth = 2 ** binW;

    logic [countW-1:0] mem [depth];
    logic [binW-1:0]   rdAddr;
    logic [binW-1:0]   wrAddr;
    logic              wrEn;
    logic [countW-1:0] wrData;

    // readout owns both ports while it runs
    assign rdAddr = roBusy ? roRdAddr : accRdAddr;
    assign wrEn   = roBusy ? roWrEn : accWrEn;
    assign wrAddr = roBusy ? roWrAddr : accWrAddr;
    assign wrData = roBusy ? '0 : accWrData; // readout only ever clears

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0; // histogram starts empty at power-up
        end
    end

    always @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // one cycle read latency, old data on a same-address write
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bankRdData <= '0;
        end else begin
            bankRdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- src/histAccumulator.sv
`default_nettype none

module histAccumulator #(
    parameter int binW   = sifhPkg::binWDef,
    parameter int countW = sifhPkg::countWDef,
    parameter int acqLen = sifhPkg::acqLenDef
) (
    input  logic              clk,
    input  logic              res,
    input  logic              start,
    input  logic              roBusy,
    input  logic              sampleValid,
    input  logic [binW-1:0]   sampleBin,
    output logic [binW-1:0]   accRdAddr,
    output logic              accWrEn,
    output logic [binW-1:0]   accWrAddr,
    output logic [countW-1:0] accWrData,
    input  logic [countW-1:0] bankRdData,
    output logic              acqBusy,
    output logic              acqDone
);

    import sifhPkg::*;

    localparam int cntW = (acqLen > 1) ? $clog2(acqLen) : 1;
    localparam logic [countW-1:0] countMax = '1;

    accState_t         state;
    logic [cntW-1:0]   sampleCnt;
    logic              accept;
    logic              lastSample;

    logic              s1Valid;
    logic [binW-1:0]   s1Bin;
    logic              s2Valid;
    logic [binW-1:0]   s2Bin;
    logic [countW-1:0] s2Data;
    logic              fwdHit;
    logic [countW-1:0] curCount;

    // busy until the last write has landed, so readout cannot steal the bank early
    assign acqBusy    = (state != accIdle);
    assign accept     = (state == accRun) && sampleValid;
    assign lastSample = accept && (sampleCnt == cntW'(acqLen - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= accIdle;
            sampleCnt <= '0;
            acqDone   <= 1'b0;
        end else begin
            acqDone <= 1'b0;
            case (state)
                accIdle: begin
                    if (start && !roBusy) begin // readout has the bank
                        state     <= accRun;
                        sampleCnt <= '0;
                    end
                end
                accRun: begin
                    if (accept) begin
                        sampleCnt <= sampleCnt + 1'b1;
                        if (lastSample) begin
                            state <= accDrain;
                        end
                    end
                end
                accDrain: begin
                    state   <= accIdle; // final write lands this cycle
                    acqDone <= 1'b1;
                end
                default: begin
                    state <= accIdle;
                end
            endcase
        end
    end

    // stage 0 reads, stage 1 writes, stage 2 remembers the last write
    assign accRdAddr = sampleBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            s1Valid <= accept;
            s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin  <= sampleBin;
        s2Bin  <= s1Bin;
        s2Data <= accWrData;
    end

    // RAM read missed the write made one cycle earlier to the same bin
    assign fwdHit   = s2Valid && (s2Bin == s1Bin);
    assign curCount = fwdHit ? s2Data : bankRdData;

    assign accWrEn   = s1Valid;
    assign accWrAddr = s1Bin;
    assign accWrData = (curCount == countMax) ? curCount : curCount + 1'b1; // saturate

endmodule

`default_nettype wire

//--- src/histReadout.sv
`default_nettype none

module histReadout #(
    parameter int binW   = sifhPkg::binWDef,
    parameter int countW = sifhPkg::countWDef
) (
    input  logic              clk,
    input  logic              res,
    input  logic              rdStart,
    input  logic              acqBusy,
    output logic              roBusy,
    output logic [binW-1:0]   roRdAddr,
    output logic              roWrEn,
    output logic [binW-1:0]   roWrAddr,
    input  logic [countW-1:0] bankRdData,
    output logic              rdValid,
    output logic [binW-1:0]   rdBin,
    output logic [countW-1:0] rdCount,
    output logic              rdDone
);

    import sifhPkg::*;

    localparam logic [binW-1:0] lastBin = '1;

    rdState_t        state;
    logic            accepted;
    logic [binW-1:0] addrCnt;
    logic [binW-1:0] prevAddr;
    logic            streamQ;

    assign accepted = (state == rdIdle) && rdStart && !acqBusy;

    // claims the bank already in the rdStart cycle so a start in the
    // same cycle loses to readout
    assign roBusy = (state != rdIdle) || accepted;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= rdIdle;
            addrCnt <= '0;
            streamQ <= 1'b0;
        end else begin
            streamQ <= (state == rdRun); // data of this read shows next cycle
            case (state)
                rdIdle: begin
                    if (accepted) begin
                        state   <= rdRun;
                        addrCnt <= '0;
                    end
                end
                rdRun: begin
                    if (addrCnt == lastBin) begin
                        state <= rdLast;
                    end else begin
                        addrCnt <= addrCnt + 1'b1;
                    end
                end
                rdLast: begin
                    state <= rdIdle;
                end
                default: begin
                    state <= rdIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        prevAddr <= addrCnt; // bin whose count is on bankRdData
    end

    assign roRdAddr = addrCnt;

    // clear the bin in the same cycle it is streamed
    assign roWrEn   = streamQ;
    assign roWrAddr = prevAddr;

    assign rdValid = streamQ;
    assign rdBin   = prevAddr;
    assign rdCount = bankRdData;
    assign rdDone  = (state == rdLast);

endmodule

`default_nettype wire

//--- src/sifhTop.sv
`default_nettype none

module sifhTop #(
    parameter int binW   = sifhPkg::binWDef,
    parameter int countW = sifhPkg::countWDef,
    parameter int acqLen = sifhPkg::acqLenDef
) (
    input  logic              clk,
    input  logic              res,
    input  logic              start,
    input  logic              sampleValid,
    input  logic [binW-1:0]   sampleBin,
    input  logic              rdStart,
    output logic              acqBusy,
    output logic              acqDone,
    output logic              rdValid,
    output logic [binW-1:0]   rdBin,
    output logic [countW-1:0] rdCount,
    output logic              rdDone
);

    logic [binW-1:0]   accRdAddr;
    logic              accWrEn;
    logic [binW-1:0]   accWrAddr;
    logic [countW-1:0] accWrData;
    logic              roBusy;
    logic [binW-1:0]   roRdAddr;
    logic              roWrEn;
    logic [binW-1:0]   roWrAddr;
    logic [countW-1:0] bankRdData; // shared by both clients

    histAccumulator #(
        .binW   (binW),
        .countW (countW),
        .acqLen (acqLen)
    ) uAcc (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .roBusy      (roBusy),
        .sampleValid (sampleValid),
        .sampleBin   (sampleBin),
        .accRdAddr   (accRdAddr),
        .accWrEn     (accWrEn),
        .accWrAddr   (accWrAddr),
        .accWrData   (accWrData),
        .bankRdData  (bankRdData),
        .acqBusy     (acqBusy),
        .acqDone     (acqDone)
    );

    histReadout #(
        .binW   (binW),
        .countW (countW)
    ) uRo (
        .clk        (clk),
        .res        (res),
        .rdStart    (rdStart),
        .acqBusy    (acqBusy),
        .roBusy     (roBusy),
        .roRdAddr   (roRdAddr),
        .roWrEn     (roWrEn),
        .roWrAddr   (roWrAddr),
        .bankRdData (bankRdData),
        .rdValid    (rdValid),
        .rdBin      (rdBin),
        .rdCount    (rdCount),
        .rdDone     (rdDone)
    );

    histBank #(
        .binW   (binW),
        .countW (countW)
    ) uBank (
        .clk        (clk),
        .res        (res),
        .roBusy     (roBusy),
        .accRdAddr  (accRdAddr),
        .accWrEn    (accWrEn),
        .accWrAddr  (accWrAddr),
        .accWrData  (accWrData),
        .roRdAddr   (roRdAddr),
        .roWrEn     (roWrEn),
        .roWrAddr   (roWrAddr),
        .bankRdData (bankRdData)
    );

endmodule

`default_nettype wire

//--- dv/sifhChk.sv
`default_nettype none

module sifhChk (
    input logic clk,
    input logic res,
    input logic donePulse,
    input logic wrActive,
    input logic otherBusy
);

    // done strobes last exactly one cycle
    donePulseSingle: assert property (
        @(posedge clk) disable iff (!res) donePulse |=> !donePulse
    ) else $error("done pulse held for more than one cycle");

    // a client never writes while the other one owns the bank
    noWriteOverlap: assert property (
        @(posedge clk) disable iff (!res) !(wrActive && otherBusy)
    ) else $error("write while the other client owns the bank");

endmodule

bind histAccumulator sifhChk accChk (
    .clk       (clk),
    .res       (res),
    .donePulse (acqDone),
    .wrActive  (accWrEn),
    .otherBusy (roBusy)
);

// rdValid doubles as the clearing write enable
bind histReadout sifhChk roChk (
    .clk       (clk),
    .res       (res),
    .donePulse (rdDone),
    .wrActive  (rdValid),
    .otherBusy (acqBusy)
);

`default_nettype wire

//--- dv/sifhTbTasks.svh
`ifndef SIFH_TB_TASKS_SVH
`define SIFH_TB_TASKS_SVH

// expected count of one bin from the recorded hits
function automatic logic [countW-1:0] expectCount(input int bin);
    int capped;
    capped = (hits[bin] > countMax) ? countMax : hits[bin]; // counts saturate
    return capped[countW-1:0];
endfunction

task automatic checkCount(input logic [countW-1:0] got, input logic [countW-1:0] exp,
                          input int bin);
    if (got !== exp) begin
        errCount++;
        $display("Fail at %0t: rdCount got %0d expected %0d (bin %0d)", $time, got, exp, bin);
    end
endtask

task automatic checkBin(input logic [binW-1:0] got, input logic [binW-1:0] exp);
    if (got !== exp) begin
        errCount++;
        $display("Fail at %0t: rdBin got %0d expected %0d", $time, got, exp);
    end
endtask

task automatic checkPulse(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errCount++;
        $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

// wait for acqDone or rdDone, sampled at the falling edge
task automatic waitDone(input bit readout);
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < timeoutCycles) begin
        @(negedge clk);
        n++;
        seen = readout ? rdDone : acqDone;
    end
    if (!seen) begin
        timeoutCount++;
        $display("Timeout at %0t: no %s pulse within %0d cycles", $time,
                 readout ? "rdDone" : "acqDone", timeoutCycles);
    end
endtask

`endif

//--- dv/sifhTb.sv
`default_nettype none

module sifhTb;

    import sifhPkg::*;

    localparam int binW          = binWDef;
    localparam int countW        = 8; // small enough to saturate
    localparam int acqLen        = 300;
    localparam int nBins         = 2 ** binW;
    localparam int countMax      = (1 << countW) - 1;
    localparam int timeoutCycles = 200;

    logic              clk;
    logic              res;
    logic              start;
    logic              sampleValid;
    logic [binW-1:0]   sampleBin;
    logic              rdStart;
    logic              acqBusy;
    logic              acqDone;
    logic              rdValid;
    logic [binW-1:0]   rdBin;
    logic [countW-1:0] rdCount;
    logic              rdDone;

    int         seed;
    int         errCount;
    int         timeoutCount;
    int         hits [nBins]; // model of the histogram
    int         acqCount;     // samples accepted in this acquisition
    int         expBin;
    int         beatCount;
    logic       rdArmed;      // a readout was started on purpose
    logic       busyQ;
    logic [1:0] doneSr;       // acqDone is due two edges after the last sample

    `include "sifhTbTasks.svh"

    sifhTop #(
        .binW   (binW),
        .countW (countW),
        .acqLen (acqLen)
    ) DUT (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .sampleValid (sampleValid),
        .sampleBin   (sampleBin),
        .rdStart     (rdStart),
        .acqBusy     (acqBusy),
        .acqDone     (acqDone),
        .rdValid     (rdValid),
        .rdBin       (rdBin),
        .rdCount     (rdCount),
        .rdDone      (rdDone)
    );

    always #5 clk = ~clk;

    task automatic driveSample(input logic valid, input logic [binW-1:0] bin);
        @(posedge clk);
        #1;
        sampleValid = valid;
        sampleBin   = bin;
    endtask

    task automatic startAcq();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        checkPulse("acqBusy", acqBusy, 1'b1);
    endtask

    // pokeStart sends a start pulse while the readout runs
    task automatic runReadout(input bit pokeStart);
        beatCount = 0;
        @(posedge clk);
        #1;
        rdStart = 1'b1;
        rdArmed = 1'b1;
        @(posedge clk);
        #1;
        rdStart = 1'b0;
        if (pokeStart) begin
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            @(negedge clk);
            checkPulse("acqBusy", acqBusy, 1'b0); // start must be ignored
        end
        waitDone(1'b1);
        @(posedge clk);
        if (beatCount != nBins) begin
            errCount++;
            $display("Readout at %0t streamed %0d bins instead of %0d", $time, beatCount, nBins);
        end
    endtask

    // model and compare at the falling edge
    always @(negedge clk) begin
        logic lastNow;
        if (res) begin
            lastNow = 1'b0;
            if (acqBusy && !busyQ) begin
                acqCount = 0; // new acquisition
            end
            if (acqBusy && sampleValid && acqCount < acqLen) begin
                hits[sampleBin]++;
                acqCount++;
                lastNow = (acqCount == acqLen);
            end
            checkPulse("acqDone", acqDone, doneSr[1]);
            doneSr = {doneSr[0], lastNow};
            busyQ  = acqBusy;
            if (rdValid) begin
                if (!rdArmed || acqBusy) begin
                    errCount++;
                    $display("rdValid at %0t without an accepted rdStart", $time);
                end
                checkBin(rdBin, binW'(expBin));
                checkCount(rdCount, expectCount(expBin), expBin);
                checkPulse("rdDone", rdDone, expBin == nBins - 1);
                hits[expBin] = 0; // readout clears the bin
                expBin = (expBin + 1) % nBins;
                beatCount++;
                if (rdDone) begin
                    rdArmed = 1'b0;
                end
            end else begin
                checkPulse("rdDone", rdDone, 1'b0);
            end
            if (DUT.accWrEn && DUT.roWrEn) begin
                errCount++;
                $display("Both clients wrote the bank in one cycle at %0t", $time);
            end
        end
    end

    initial begin
        int r;
        int gap;
        int runLen;
        int sent;
        logic [binW-1:0] runBin;

        seed         = 65;
        errCount     = 0;
        timeoutCount = 0;
        acqCount     = 0;
        expBin       = 0;
        beatCount    = 0;
        rdArmed      = 1'b0;
        busyQ        = 1'b0;
        doneSr       = 2'b00;
        clk          = 1'b0;
        res          = 1'b0;
        start        = 1'b0;
        sampleValid  = 1'b0;
        sampleBin    = '0;
        rdStart      = 1'b0;
        for (int b = 0; b < nBins; b++) begin
            hits[b] = 0;
        end

        repeat (10) @(posedge clk);
        #1;
        res = 1'b1;
        @(negedge clk);
        checkPulse("acqBusy", acqBusy, 1'b0);
        checkPulse("acqDone", acqDone, 1'b0);
        checkPulse("rdValid", rdValid, 1'b0);
        checkPulse("rdDone", rdDone, 1'b0);
        runReadout(1'b0); // fresh memory reads as zero

        // random bins with random gaps
        startAcq();
        for (int i = 0; i < acqLen; i++) begin
            r   = $random(seed);
            gap = r & 3;
            repeat (gap) driveSample(1'b0, '0);
            r = $random(seed);
            driveSample(1'b1, r[binW-1:0]);
        end
        driveSample(1'b0, '0);
        waitDone(1'b0);
        runReadout(1'b0);

        // long same-bin runs on every cycle hit the forwarding path
        startAcq();
        sent = 0;
        while (sent < acqLen) begin
            r      = $random(seed);
            runBin = r[binW-1:0];
            runLen = 1 + ((r >> 8) & 31);
            for (int j = 0; j < runLen && sent < acqLen; j++) begin
                driveSample(1'b1, runBin);
                sent++;
            end
        end
        driveSample(1'b0, '0);
        waitDone(1'b0);
        runReadout(1'b0);

        // one bin hit beyond the count limit
        startAcq();
        repeat (acqLen) driveSample(1'b1, binW'(13));
        driveSample(1'b0, '0);
        waitDone(1'b0);
        runReadout(1'b0);
        runReadout(1'b0); // everything cleared by the previous pass

        // idle samples are dropped and a start during readout is ignored
        repeat (20) begin
            r = $random(seed);
            driveSample(1'b1, r[binW-1:0]);
        end
        driveSample(1'b0, '0);
        runReadout(1'b1);

        // rdStart during acquisition is ignored
        startAcq();
        for (int i = 0; i < acqLen; i++) begin
            driveSample(1'b1, binW'(i));
            if (i == 40) begin
                rdStart = 1'b1;
            end else begin
                rdStart = 1'b0;
            end
        end
        driveSample(1'b0, '0);
        waitDone(1'b0);
        runReadout(1'b0);

        repeat (5) @(posedge clk);
        $display("errors: %0d, timeouts: %0d", errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sifhTop.f
+incdir+dv
src/sifhPkg.sv
src/histBank.sv
src/histAccumulator.sv
src/histReadout.sv
src/sifhTop.sv
dv/sifhChk.sv
dv/sifhTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the histogram testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -f sifhTop.f --top-module sifhTb \
    -Mdir "$buildDir" -o sifhSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$buildDir/sifhSim" +verilator+error+limit+1000 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$logFile"; then
    echo "result: pass"
    exit 0
fi

echo "result: fail"
exit 1
